/* common/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;

  typedef logic [XLEN-1:0] word_t;       // Register data, immediates, pc values
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [1:0]      src_a_sel_t;
  typedef logic            src_b_sel_t;

  localparam word_t PC_STEP = 32'd4;

  // Opcode map, inst[6:0]
  localparam logic [6:0] OP_R       = 7'b0110011;
  localparam logic [6:0] OP_I_ARITH = 7'b0010011;
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;

  // funct3 field, shared by R-type and I-type arithmetic
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;

  // Operand A source
  localparam src_a_sel_t SRC_A_REG  = 2'd0;
  localparam src_a_sel_t SRC_A_PC   = 2'd1;  // auipc
  localparam src_a_sel_t SRC_A_ZERO = 2'd2;  // lui

  // Operand B source
  localparam src_b_sel_t SRC_B_REG = 1'b0;
  localparam src_b_sel_t SRC_B_IMM = 1'b1;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    alu_op_t    alu_op;
    src_a_sel_t src_a_sel;
    src_b_sel_t src_b_sel;
    logic       regwrite;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    logic      regwrite;
    word_t     result;
  } ex_res_t;

  // we is never set for x0
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    word_t     data;
  } retire_t;

endpackage

/* core/alu.sv */
module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  output rv_pkg::word_t   y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];  // Upper bits of b ignored for shifts

  always_comb
  begin
    case (op)
      rv_pkg::ALU_ADD:  y = a + b;
      rv_pkg::ALU_SUB:  y = a - b;
      rv_pkg::ALU_AND:  y = a & b;
      rv_pkg::ALU_OR:   y = a | b;
      rv_pkg::ALU_XOR:  y = a ^ b;
      rv_pkg::ALU_SLL:  y = a << shamt;
      rv_pkg::ALU_SRL:  y = a >> shamt;
      rv_pkg::ALU_SRA:  y = $signed(a) >>> shamt;
      rv_pkg::ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU: y = {31'b0, a < b};
      default:          y = '0;
    endcase
  end

endmodule

/* core/reg_file.sv */
module reg_file (
  input  logic              clk,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::wb_t       wb
);

  // x0 has no storage
  rv_pkg::word_t regs [1:rv_pkg::REG_COUNT-1];

  // wb.we already excludes x0
  always_ff @(posedge clk)
  begin
    if (wb.we)
      regs[wb.rd] <= wb.data;
  end

  // Asynchronous reads
  always_comb
  begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1 != '0)
      rs1_data = regs[rs1];
    if (rs2 != '0)
      rs2_data = regs[rs2];
  end

endmodule

/* core/decode_stage.sv */
module decode_stage (
  input  logic              clk,
  input  logic              reset,
  output rv_pkg::word_t     pc,
  input  rv_pkg::word_t     inst,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::wb_t       wb,
  output rv_pkg::id_ex_t    id_ex
);

  logic              if_valid;
  rv_pkg::word_t     if_pc;
  rv_pkg::word_t     if_inst;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              legal;
  rv_pkg::id_ex_t    id_ex_d;

  // Sequential fetch, no redirects
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else
      pc <= pc + rv_pkg::PC_STEP;
  end

  // Fetch/decode register, empty in the first cycle after reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      if_valid <= 1'b0;
    else
    begin
      if_valid <= 1'b1;
      if_pc    <= pc;
      if_inst  <= inst;
    end
  end

  assign opcode = if_inst[6:0];
  assign funct3 = if_inst[14:12];
  assign funct7 = if_inst[31:25];
  assign rs1    = if_inst[19:15];
  assign rs2    = if_inst[24:20];

  always_comb
  begin
    legal             = 1'b0;
    id_ex_d.alu_op    = rv_pkg::ALU_ADD;
    id_ex_d.src_a_sel = rv_pkg::SRC_A_REG;
    id_ex_d.src_b_sel = rv_pkg::SRC_B_REG;
    id_ex_d.imm       = {{20{if_inst[31]}}, if_inst[31:20]};  // I-type
    case (opcode)
      rv_pkg::OP_R:
      begin
        legal = 1'b1;
        case (funct3)
          rv_pkg::F3_ADD_SUB: id_ex_d.alu_op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SUB
                                                                           : rv_pkg::ALU_ADD;
          rv_pkg::F3_SLL:     id_ex_d.alu_op = rv_pkg::ALU_SLL;
          rv_pkg::F3_SLT:     id_ex_d.alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_SLTU:    id_ex_d.alu_op = rv_pkg::ALU_SLTU;
          rv_pkg::F3_XOR:     id_ex_d.alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_SRL_SRA: id_ex_d.alu_op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SRA
                                                                           : rv_pkg::ALU_SRL;
          rv_pkg::F3_OR:      id_ex_d.alu_op = rv_pkg::ALU_OR;
          default:            id_ex_d.alu_op = rv_pkg::ALU_AND;
        endcase
        // Alternate funct7 only for sub and sra
        if (funct7 == rv_pkg::F7_ALT)
          legal = (funct3 == rv_pkg::F3_ADD_SUB) || (funct3 == rv_pkg::F3_SRL_SRA);
        else if (funct7 != rv_pkg::F7_BASE)
          legal = 1'b0;
      end
      rv_pkg::OP_I_ARITH:
      begin
        legal             = 1'b1;
        id_ex_d.src_b_sel = rv_pkg::SRC_B_IMM;
        case (funct3)
          rv_pkg::F3_ADD_SUB: id_ex_d.alu_op = rv_pkg::ALU_ADD;
          rv_pkg::F3_SLT:     id_ex_d.alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_SLTU:    id_ex_d.alu_op = rv_pkg::ALU_SLTU;
          rv_pkg::F3_XOR:     id_ex_d.alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_OR:      id_ex_d.alu_op = rv_pkg::ALU_OR;
          rv_pkg::F3_AND:     id_ex_d.alu_op = rv_pkg::ALU_AND;
          rv_pkg::F3_SLL:
          begin
            id_ex_d.alu_op = rv_pkg::ALU_SLL;
            legal          = (funct7 == rv_pkg::F7_BASE);
          end
          default:            // srli / srai
          begin
            id_ex_d.alu_op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            legal          = (funct7 == rv_pkg::F7_BASE) || (funct7 == rv_pkg::F7_ALT);
          end
        endcase
      end
      rv_pkg::OP_LUI:
      begin
        legal             = 1'b1;
        id_ex_d.src_a_sel = rv_pkg::SRC_A_ZERO;
        id_ex_d.src_b_sel = rv_pkg::SRC_B_IMM;
        id_ex_d.imm       = {if_inst[31:12], 12'b0};
      end
      rv_pkg::OP_AUIPC:
      begin
        legal             = 1'b1;
        id_ex_d.src_a_sel = rv_pkg::SRC_A_PC;
        id_ex_d.src_b_sel = rv_pkg::SRC_B_IMM;
        id_ex_d.imm       = {if_inst[31:12], 12'b0};
      end
      default: legal = 1'b0;  // Loads, stores, branches, jumps and the rest
    endcase

    id_ex_d.valid    = if_valid && legal;  // Illegal encodings become bubbles
    id_ex_d.regwrite = legal;
    id_ex_d.pc       = if_pc;
    id_ex_d.rd       = if_inst[11:7];
    id_ex_d.rs1      = rs1;
    id_ex_d.rs2      = rs2;
    // Result stage writes the regfile this same cycle
    id_ex_d.rs1_data = (wb.we && wb.rd == rs1) ? wb.data : rs1_data;
    id_ex_d.rs2_data = (wb.we && wb.rd == rs2) ? wb.data : rs2_data;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex.valid <= 1'b0;
    else
      id_ex <= id_ex_d;
  end

endmodule

/* core/execute_stage.sv */
module execute_stage (
  input  rv_pkg::id_ex_t  id_ex,
  input  rv_pkg::ex_res_t fwd,
  output rv_pkg::ex_res_t ex_res
);

  rv_pkg::word_t reg_a;
  rv_pkg::word_t reg_b;
  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_y;

  // Older value from the instruction one ahead, if it writes rs
  function automatic rv_pkg::word_t forward(
    input rv_pkg::reg_addr_t rs,
    input rv_pkg::word_t     rf_value,
    input rv_pkg::ex_res_t   ahead
  );
    if (ahead.valid && ahead.regwrite && ahead.rd != '0 && ahead.rd == rs)
      return ahead.result;
    return rf_value;
  endfunction

  assign reg_a = forward(id_ex.rs1, id_ex.rs1_data, fwd);
  assign reg_b = forward(id_ex.rs2, id_ex.rs2_data, fwd);

  always_comb
  begin
    case (id_ex.src_a_sel)
      rv_pkg::SRC_A_PC:   op_a = id_ex.pc;
      rv_pkg::SRC_A_ZERO: op_a = '0;
      default:            op_a = reg_a;
    endcase
  end

  assign op_b = (id_ex.src_b_sel == rv_pkg::SRC_B_IMM) ? id_ex.imm : reg_b;

  alu i_alu (
    .a  (op_a),
    .b  (op_b),
    .op (id_ex.alu_op),
    .y  (alu_y)
  );

  // Registered by the result stage
  always_comb
  begin
    ex_res.valid    = id_ex.valid;
    ex_res.pc       = id_ex.pc;
    ex_res.rd       = id_ex.rd;
    ex_res.regwrite = id_ex.regwrite;
    ex_res.result   = alu_y;
  end

endmodule

/* core/result_stage.sv */
module result_stage (
  input  logic            clk,
  input  logic            reset,
  input  rv_pkg::ex_res_t ex_res,
  output rv_pkg::ex_res_t held,
  output rv_pkg::wb_t     wb,
  output rv_pkg::retire_t retire,
  output rv_pkg::word_t   retired_count
);

  // Execute/result register, also the execute forwarding source
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      held.valid <= 1'b0;
    else
      held <= ex_res;
  end

  always_comb
  begin
    wb.we   = held.valid && held.regwrite && held.rd != '0;  // x0 stays zero
    wb.rd   = held.rd;
    wb.data = held.result;
  end

  // Writes to x0 still retire
  always_comb
  begin
    retire.valid = held.valid;
    retire.pc    = held.pc;
    retire.rd    = held.rd;
    retire.data  = held.result;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      retired_count <= '0;
    else if (held.valid)
      retired_count <= retired_count + 1'b1;
  end

endmodule

/* rtl/rv32i_core.sv */
module rv32i_core (
  input  logic            clk,
  input  logic            reset,
  output rv_pkg::word_t   pc,
  input  rv_pkg::word_t   inst,
  output rv_pkg::retire_t retire,
  output rv_pkg::word_t   retired_count
);

  rv_pkg::id_ex_t    id_ex;
  rv_pkg::ex_res_t   ex_res;
  rv_pkg::ex_res_t   held;      // One instruction ahead of execute
  rv_pkg::wb_t       wb;
  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;

  decode_stage i_decode_stage (
    .clk      (clk),
    .reset    (reset),
    .pc       (pc),
    .inst     (inst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb),
    .id_ex    (id_ex)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  execute_stage i_execute_stage (
    .id_ex  (id_ex),
    .fwd    (held),
    .ex_res (ex_res)
  );

  result_stage i_result_stage (
    .clk           (clk),
    .reset         (reset),
    .ex_res        (ex_res),
    .held          (held),
    .wb            (wb),
    .retire        (retire),
    .retired_count (retired_count)
  );

endmodule

/* verif/rv32i_core_tb.sv */
module rv32i_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_LEN    = 200;
  localparam int MAX_CYCLES  = 260;  // Program length plus 60 cycles of margin
  localparam int DRAIN       = 8;
  localparam int RESET_TICKS = 4;

  typedef struct packed {
    rv_pkg::word_t     pc;
    rv_pkg::reg_addr_t rd;
    rv_pkg::word_t     data;
  } expect_t;

  logic            clk;
  logic            reset;
  rv_pkg::word_t   pc;
  rv_pkg::word_t   inst;
  rv_pkg::retire_t retire;
  rv_pkg::word_t   retired_count;

  rv_pkg::word_t prog [PROG_LEN];
  int            fetch_cycle [PROG_LEN];
  rv_pkg::word_t isa_regs [8];     // Only x0 to x7 are used
  int            last_writer [8];
  int            dist_hits [1:3];  // Dependencies by distance
  expect_t       exp_q [$];
  int            legal_count;
  int            cycle;
  int            value_errors;
  int            order_errors;
  int            other_errors;
  bit            seen_retire;

  rv32i_core dut0 (
    .clk           (clk),
    .reset         (reset),
    .pc            (pc),
    .inst          (inst),
    .retire        (retire),
    .retired_count (retired_count)
  );

  always #10 clk = ~clk;

  // RV32I integer semantics selected by funct3
  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh)) : a >> sh;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic note_source(input int idx, input logic [2:0] r);
    if (r != 3'd0 && last_writer[r] >= 0 && idx - last_writer[r] <= 3)
      dist_hits[idx - last_writer[r]]++;
  endtask

  // Random program run through the ISA model as it is built
  task automatic build_program();
    int            sel;
    logic [2:0]    rd, rs1, rs2, f3;
    logic          alt;
    logic          legal;
    logic [11:0]   imm;
    rv_pkg::word_t raw, fields, word, result, pc_i;
    for (int i = 0; i < PROG_LEN; i++)
    begin
      sel    = $urandom % 100;
      raw    = $urandom;
      fields = $urandom;
      rd     = fields[2:0];
      rs1    = fields[5:3];
      rs2    = fields[8:6];
      f3     = fields[11:9];
      alt    = raw[30] && (f3 == 3'b000 || f3 == 3'b101);
      pc_i   = i * 4;
      legal  = 1'b1;
      if (i < 7)  // addi x1..x7 from x0 so every register is written before it is read
      begin
        sel = 60;
        rd  = i + 1;
        rs1 = 3'd0;
        f3  = 3'b000;
      end
      if (sel < 10)
      begin
        word   = {raw[31:12], 2'b0, rd, rv_pkg::OP_LUI};
        result = {raw[31:12], 12'b0};
      end
      else if (sel < 20)
      begin
        word   = {raw[31:12], 2'b0, rd, rv_pkg::OP_AUIPC};
        result = pc_i + {raw[31:12], 12'b0};
      end
      else if (sel < 60)
      begin
        word = {1'b0, alt, 5'b0, 2'b0, rs2, 2'b0, rs1, f3, 2'b0, rd, rv_pkg::OP_R};
        note_source(i, rs1);
        note_source(i, rs2);
        result = alu_ref(f3, alt, isa_regs[rs1], isa_regs[rs2]);
      end
      else if (sel < 90)
      begin
        if (f3 == 3'b000)
          alt = 1'b0;  // No subi
        if (f3 == 3'b001 || f3 == 3'b101)
          imm = {1'b0, alt, 5'b0, raw[4:0]};
        else
          imm = raw[11:0];
        word = {imm, 2'b0, rs1, f3, 2'b0, rd, rv_pkg::OP_I_ARITH};
        note_source(i, rs1);
        result = alu_ref(f3, alt, isa_regs[rs1], {{20{imm[11]}}, imm});
      end
      else
      begin
        legal  = 1'b0;
        result = '0;
        case (fields[13:12])
          2'd0:    word = {raw[31:7], 7'b0100011};  // Store
          2'd1:    word = {raw[31:7], 7'b1100011};  // Branch
          2'd2:    word = {raw[31:7], 7'b0000011};  // Load
          default: word = {7'b0000001, raw[24:7], rv_pkg::OP_R};  // M-extension funct7
        endcase
      end
      prog[i] = word;
      if (legal)
      begin
        legal_count++;
        exp_q.push_back(expect_t'{pc_i, {2'b0, rd}, result});
        if (rd != 3'd0)
        begin
          isa_regs[rd]    = result;
          last_writer[rd] = i;
        end
      end
    end
  endtask

  // Check this cycle's retirement and answer the fetch
  task automatic observe();
    expect_t e;
    int      idx;
    if (retire.valid)
    begin
      assert (exp_q.size() > 0)
      else
      begin
        $display("ERROR %0t: unexpected retirement at pc %h", $time, retire.pc);
        order_errors++;
      end
      if (exp_q.size() > 0)
      begin
        e = exp_q.pop_front();
        assert (seen_retire || retire.pc == '0)
        else
        begin
          $display("ERROR %0t: first retirement at pc %h, not 0", $time, retire.pc);
          order_errors++;
        end
        assert (retire.pc === e.pc)
        else
        begin
          $display("ERROR %0t: retired pc %h, expected %h", $time, retire.pc, e.pc);
          order_errors++;
        end
        assert (retire.rd === e.rd && retire.data === e.data)
        else
        begin
          $display("ERROR %0t: pc %h retired x%0d=%h, expected x%0d=%h", $time, retire.pc,
                   retire.rd, retire.data, e.rd, e.data);
          value_errors++;
        end
        idx = retire.pc >> 2;
        if (idx < PROG_LEN)
        begin
          assert (cycle - fetch_cycle[idx] == 3)
          else
          begin
            $display("ERROR %0t: pc %h retired %0d cycles after fetch", $time, retire.pc,
                     cycle - fetch_cycle[idx]);
            order_errors++;
          end
        end
      end
      seen_retire = 1'b1;
    end
    // No stalls, so the fetch address steps once per cycle
    assert (pc === rv_pkg::word_t'(cycle * 4))
    else
    begin
      $display("ERROR %0t: pc %h in cycle %0d, expected %h", $time, pc, cycle,
               rv_pkg::word_t'(cycle * 4));
      order_errors++;
    end
    idx = pc >> 2;
    if (idx < PROG_LEN)
    begin
      inst             = prog[idx];
      fetch_cycle[idx] = cycle;
    end
    else
      inst = '0;  // Illegal past the end
  endtask

  initial
  begin
    void'($urandom(32'h5f29846c));
    clk          = 1'b0;
    reset        = 1'b1;
    inst         = '0;
    legal_count  = 0;
    cycle        = 0;
    value_errors = 0;
    order_errors = 0;
    other_errors = 0;
    seen_retire  = 1'b0;
    for (int r = 0; r < 8; r++)
    begin
      isa_regs[r]    = '0;
      last_writer[r] = -1;
    end
    for (int d = 1; d <= 3; d++)
      dist_hits[d] = 0;
    build_program();

    repeat (RESET_TICKS)
    begin
      @(negedge clk);
      assert (retire.valid === 1'b0 && retired_count === '0)
      else
      begin
        $display("ERROR %0t: retirement activity during reset", $time);
        order_errors++;
      end
      inst = prog[0];
    end
    reset = 1'b0;
    observe();  // Cycle 0 with address 0 on pc

    while (exp_q.size() > 0 && cycle < MAX_CYCLES)
    begin
      @(negedge clk);
      cycle++;
      observe();
    end
    if (exp_q.size() > 0)
    begin
      $display("Run did not finish: %0d instructions never retired within %0d cycles",
               exp_q.size(), MAX_CYCLES);
      other_errors++;
    end
    else
      repeat (DRAIN)  // Trailing illegal fetches must not retire
      begin
        @(negedge clk);
        cycle++;
        observe();
      end

    assert (retired_count == legal_count)
    else
    begin
      $display("ERROR %0t: retired_count %0d, expected %0d", $time, retired_count, legal_count);
      value_errors++;
    end
    for (int d = 1; d <= 3; d++)
      assert (dist_hits[d] > 0)
      else
      begin
        $display("The program has no dependency at distance %0d", d);
        other_errors++;
      end

    $display("Errors: value %0d, order %0d, other %0d", value_errors, order_errors,
             other_errors);
    if (value_errors + order_errors + other_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* list.f */
common/rv_pkg.sv
core/alu.sv
core/reg_file.sv
core/decode_stage.sv
core/execute_stage.sv
core/result_stage.sv
rtl/rv32i_core.sv
verif/rv32i_core_tb.sv

/* Bender.yml */
package:
  name: rv32i_core

sources:
  - common/rv_pkg.sv
  - core/alu.sv
  - core/reg_file.sv
  - core/decode_stage.sv
  - core/execute_stage.sv
  - core/result_stage.sv
  - rtl/rv32i_core.sv
  - target: simulation
    files:
      - verif/rv32i_core_tb.sv
